/* arcade_defines.svh */
`ifndef ARCADE_DEFINES_SVH
`define ARCADE_DEFINES_SVH

`define STATUS_W      32
`define JOY_W         8
`define SAMPLE_W      16
`define APB_ADDR_W    8

// ps/2 set 2 scancodes
`define KEY_UP        8'h75
`define KEY_DOWN      8'h72
`define KEY_LEFT      8'h6B
`define KEY_RIGHT     8'h74
`define KEY_COIN      8'h76 // esc
`define KEY_START1    8'h05 // f1
`define KEY_START2    8'h06 // f2
`define KEY_FIRE1     8'h29 // space
`define KEY_FIRE2     8'h11 // alt

`define ST_RESET      0
`define ST_ROTATE     2 // zero means rotated
`define ST_SOFT_RESET 6

`define REG_STATUS    8'h00
`define REG_BUTTONS   8'h04

`endif

/* arcade_pkg.sv */
`include "arcade_defines.svh"

package arcade_pkg;

	typedef logic [`STATUS_W-1:0] status_t;

	typedef logic [`JOY_W-1:0] joy_t; // right, left, down, up, fire1, fire2 from bit 0

	typedef logic [7:0] scancode_t;

	typedef logic [`SAMPLE_W-1:0] sample_t;

	// right, left, down, up, fire1, fire2, coin, start1, start2 from bit 0
	typedef logic [8:0] buttons_t;

	typedef logic [2:0] colour3_t;

	typedef logic [5:0] colour6_t;

	typedef enum logic {
		apb_idle,
		apb_access // setup seen, access expected
	} apb_state_t;

endpackage

/* panel_if.sv */
`timescale 1ns/1ns

interface panel_if;
	logic up;
	logic down;
	logic left;
	logic right;
	logic fire1;
	logic fire2;
	logic coin;
	logic start1;
	logic start2;

	modport source (output up, down, left, right, fire1, fire2, coin, start1, start2);

	modport sink (input up, down, left, right, fire1, fire2, coin, start1, start2);

endinterface

/* host_status_regs.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module host_status_regs (
	input  logic                   clock_24,
	input  logic                   rst_n,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`STATUS_W-1:0]   pwdata,
	input  arcade_pkg::buttons_t   buttons,
	output logic [`STATUS_W-1:0]   prdata,
	output logic                   pready,
	output logic                   pslverr,
	output arcade_pkg::status_t    status
);
	import arcade_pkg::*;

	apb_state_t state;
	logic access;
	logic hit_status;
	logic hit_buttons;
	logic bad;

	assign access = psel & penable;
	assign hit_status = (paddr == `REG_STATUS);
	assign hit_buttons = (paddr == `REG_BUTTONS);

	// unmapped, read-only target, or penable without setup
	assign bad = ~(hit_status | hit_buttons) | (hit_buttons & pwrite) | (state != apb_access);

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			state <= apb_idle;
		end else if (psel && !penable) begin
			state <= apb_access; // setup phase
		end else begin
			state <= apb_idle;
		end
	end

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			status <= '0;
		end else if (access && pwrite && hit_status && state == apb_access) begin
			status <= pwdata;
		end
	end

	assign pready = access; // no wait states
	assign pslverr = access & bad;

	always_comb begin
		if (hit_status) begin
			prdata = status;
		end else if (hit_buttons) begin
			prdata = {{(`STATUS_W - $bits(buttons_t)){1'b0}}, buttons};
		end else begin
			prdata = '0;
		end
	end

endmodule

/* key_decoder.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module key_decoder (
	input  logic                  clock_24,
	input  logic                  rst_n,
	input  logic                  key_strobe,
	input  logic                  key_pressed,
	input  arcade_pkg::scancode_t key_code,
	panel_if.source               panel
);
	logic old_strobe;
	logic toggle;

	assign toggle = (old_strobe != key_strobe);

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			old_strobe <= 1'b0;
			panel.up <= 1'b0;
			panel.down <= 1'b0;
			panel.left <= 1'b0;
			panel.right <= 1'b0;
			panel.fire1 <= 1'b0;
			panel.fire2 <= 1'b0;
			panel.coin <= 1'b0;
			panel.start1 <= 1'b0;
			panel.start2 <= 1'b0;
		end else begin
			old_strobe <= key_strobe;
			if (toggle) begin
				case (key_code)
					`KEY_UP:     panel.up <= key_pressed;
					`KEY_DOWN:   panel.down <= key_pressed;
					`KEY_LEFT:   panel.left <= key_pressed;
					`KEY_RIGHT:  panel.right <= key_pressed;
					`KEY_FIRE1:  panel.fire1 <= key_pressed;
					`KEY_FIRE2:  panel.fire2 <= key_pressed;
					`KEY_COIN:   panel.coin <= key_pressed;
					`KEY_START1: panel.start1 <= key_pressed;
					`KEY_START2: panel.start2 <= key_pressed;
					default: ; // unknown codes ignored
				endcase
			end
		end
	end

endmodule

/* control_mapper.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module control_mapper (
	input  logic                clock_24,
	input  logic                rst_n,
	input  arcade_pkg::joy_t    joystick_0,
	input  arcade_pkg::joy_t    joystick_1,
	input  arcade_pkg::status_t status,
	input  logic                reset_button,
	panel_if.sink               panel,
	output logic                up,
	output logic                down,
	output logic                left,
	output logic                right,
	output logic                fire1,
	output logic                fire2,
	output logic                coin,
	output logic                start1,
	output logic                start2,
	output logic                game_reset,
	output arcade_pkg::buttons_t buttons
);
	import arcade_pkg::*;

	buttons_t key_vec;
	logic rotated;
	logic m_up, m_down, m_left, m_right;

	assign key_vec = {panel.start2, panel.start1, panel.coin, panel.fire2, panel.fire1,
		panel.up, panel.down, panel.left, panel.right};
	assign rotated = ~status[`ST_ROTATE];

	assign m_right = panel.right | joystick_0[0] | joystick_1[0];
	assign m_left = panel.left | joystick_0[1] | joystick_1[1];
	assign m_down = panel.down | joystick_0[2] | joystick_1[2];
	assign m_up = panel.up | joystick_0[3] | joystick_1[3];

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			{up, down, left, right} <= 4'b0;
			{fire1, fire2, coin, start1, start2} <= 5'b0;
			game_reset <= 1'b0;
			buttons <= '0;
		end else begin
			up <= rotated ? m_left : m_up;
			down <= rotated ? m_right : m_down;
			left <= rotated ? m_down : m_left;
			right <= rotated ? m_up : m_right;
			fire1 <= panel.fire1 | joystick_0[4] | joystick_1[4];
			fire2 <= panel.fire2 | joystick_0[5] | joystick_1[5];
			coin <= panel.coin;
			start1 <= panel.start1;
			start2 <= panel.start2;
			game_reset <= status[`ST_RESET] | status[`ST_SOFT_RESET] | reset_button;
			buttons <= key_vec; // raw keys for read-back
		end
	end

endmodule

/* video_out.sv */
`timescale 1ns/1ns

module video_out (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  arcade_pkg::colour3_t game_r,
	input  arcade_pkg::colour3_t game_g,
	input  logic [1:0]           game_b,
	input  logic                 game_hblank,
	input  logic                 game_vblank,
	input  logic                 game_hs,
	input  logic                 game_vs,
	output arcade_pkg::colour6_t vga_r,
	output arcade_pkg::colour6_t vga_g,
	output arcade_pkg::colour6_t vga_b,
	output logic                 vga_hs,
	output logic                 vga_vs
);
	import arcade_pkg::*;

	colour3_t blue3;
	logic blank;

	assign blue3 = {game_b, game_b[0]}; // 2 to 3 bits
	assign blank = game_hblank | game_vblank;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else begin
			vga_r <= blank ? '0 : {game_r, game_r};
			vga_g <= blank ? '0 : {game_g, game_g};
			vga_b <= blank ? '0 : {blue3, blue3};
			vga_hs <= game_hs; // same delay as colours
			vga_vs <= game_vs;
		end
	end

endmodule

/* audio_dac.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module audio_dac (
	input  logic                clock_24,
	input  logic                rst_n,
	input  arcade_pkg::sample_t sample,
	output logic                audio_out
);
	logic [`SAMPLE_W:0] acc; // top bit is the carry

	// first-order sigma-delta, density of ones tracks sample / 2^16
	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[`SAMPLE_W-1:0]} + {1'b0, sample};
		end
	end

	assign audio_out = acc[`SAMPLE_W]; // registered carry

endmodule

/* arcade_io_top.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module arcade_io_top (
	input  logic                   clock_24,
	input  logic                   rst_n,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`STATUS_W-1:0]   pwdata,
	output logic [`STATUS_W-1:0]   prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   key_strobe,
	input  logic                   key_pressed,
	input  arcade_pkg::scancode_t  key_code,
	input  arcade_pkg::joy_t       joystick_0,
	input  arcade_pkg::joy_t       joystick_1,
	input  logic                   reset_button,
	input  arcade_pkg::colour3_t   game_r,
	input  arcade_pkg::colour3_t   game_g,
	input  logic [1:0]             game_b,
	input  logic                   game_hblank,
	input  logic                   game_vblank,
	input  logic                   game_hs,
	input  logic                   game_vs,
	input  arcade_pkg::sample_t    audio_sample,
	output arcade_pkg::colour6_t   vga_r,
	output arcade_pkg::colour6_t   vga_g,
	output arcade_pkg::colour6_t   vga_b,
	output logic                   vga_hs,
	output logic                   vga_vs,
	output logic                   audio_out,
	output logic                   game_up,
	output logic                   game_down,
	output logic                   game_left,
	output logic                   game_right,
	output logic                   game_fire1,
	output logic                   game_fire2,
	output logic                   game_coin,
	output logic                   game_start1,
	output logic                   game_start2,
	output logic                   game_reset
);
	import arcade_pkg::*;

	status_t status;
	buttons_t buttons;

	panel_if panel ();

	host_status_regs u_regs (
		.clock_24, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
		.buttons, .prdata, .pready, .pslverr, .status
	);

	key_decoder u_keys (
		.clock_24, .rst_n, .key_strobe, .key_pressed, .key_code,
		.panel(panel.source)
	);

	control_mapper u_mapper (
		.clock_24, .rst_n, .joystick_0, .joystick_1, .status, .reset_button,
		.panel(panel.sink),
		.up(game_up), .down(game_down), .left(game_left), .right(game_right),
		.fire1(game_fire1), .fire2(game_fire2), .coin(game_coin),
		.start1(game_start1), .start2(game_start2),
		.game_reset, .buttons
	);

	video_out u_video (
		.clock_24, .rst_n, .game_r, .game_g, .game_b, .game_hblank, .game_vblank,
		.game_hs, .game_vs, .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs
	);

	audio_dac u_dac (
		.clock_24, .rst_n, .sample(audio_sample), .audio_out
	);

endmodule

/* arcade_io_assertions.sv */
`timescale 1ns/1ns

module arcade_io_assertions (
	input logic clock_24,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic game_up,
	input logic game_down,
	input logic game_left,
	input logic game_right,
	input logic game_fire1,
	input logic game_fire2,
	input logic game_coin,
	input logic game_start1,
	input logic game_start2,
	input logic game_reset
);
	logic controls_any;

	assign controls_any = game_up | game_down | game_left | game_right | game_fire1 |
		game_fire2 | game_coin | game_start1 | game_start2 | game_reset;

	pready_in_access: assert property (@(posedge clock_24) disable iff (!rst_n)
		(psel && penable) |-> pready)
		else $error("pready low in an APB access cycle");

	slverr_in_access: assert property (@(posedge clock_24) disable iff (!rst_n)
		pslverr |-> (psel && penable))
		else $error("pslverr outside an APB access cycle");

	// one reset edge already seen by the flops
	controls_low_in_reset: assert property (@(posedge clock_24)
		(!rst_n && !$past(rst_n)) |-> !controls_any)
		else $error("game controls or game_reset high during reset");

endmodule

/* tb_arcade_io.sv */
`timescale 1ns/1ns
`include "arcade_defines.svh"

module tb_arcade_io;
	import arcade_pkg::*;

	logic clock_24;
	logic rst_n;
	logic [7:0] paddr;
	logic psel, penable, pwrite, pready, pslverr;
	status_t pwdata, prdata;
	logic key_strobe, key_pressed;
	scancode_t key_code;
	joy_t joystick_0, joystick_1;
	logic reset_button, game_hblank, game_vblank, game_hs, game_vs;
	colour3_t game_r, game_g;
	logic [1:0] game_b;
	sample_t audio_sample;
	colour6_t vga_r, vga_g, vga_b;
	logic vga_hs, vga_vs, audio_out;
	logic game_up, game_down, game_left, game_right, game_fire1, game_fire2;
	logic game_coin, game_start1, game_start2, game_reset;

	logic [31:0] lfsr = 32'h6708_6a69;
	buttons_t key_state; // model of the key registers
	status_t status_model;
	logic [8:0] exp_ctrl;
	logic exp_reset;
	logic [19:0] exp_video;
	logic ctrl_check, video_check;

	localparam scancode_t key_table [9] = '{`KEY_RIGHT, `KEY_LEFT, `KEY_DOWN, `KEY_UP,
		`KEY_FIRE1, `KEY_FIRE2, `KEY_COIN, `KEY_START1, `KEY_START2};

	arcade_io_top dut (.*);

	bind arcade_io_top arcade_io_assertions u_checks (.*);

	initial begin
		clock_24 = 1'b0;
		forever #10 clock_24 = ~clock_24;
	end

	function automatic logic [31:0] galois_step(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = galois_step(lfsr);
		end
		return v;
	endfunction

	function automatic buttons_t apply_key(buttons_t cur, scancode_t code, logic pressed);
		buttons_t nxt;
		logic [3:0] idx;
		nxt = cur;
		for (idx = 4'd0; idx < 4'd9; idx = idx + 4'd1) begin
			if (code == key_table[idx]) begin
				nxt[idx] = pressed;
			end
		end
		return nxt;
	endfunction

	// result order start2 .. right, as the game outputs are packed below
	function automatic logic [8:0] ref_controls(buttons_t k, joy_t j0, joy_t j1, status_t st);
		logic [5:0] any;
		any = k[5:0] | j0[5:0] | j1[5:0];
		if (!st[`ST_ROTATE]) begin
			any[3:0] = {any[1], any[0], any[2], any[3]}; // up<-left, down<-right, left<-down, right<-up
		end
		return {k[8:6], any};
	endfunction

	function automatic logic ref_reset(status_t st, logic button);
		return st[`ST_RESET] | st[`ST_SOFT_RESET] | button;
	endfunction

	function automatic logic [19:0] ref_video(colour3_t r, colour3_t g, logic [1:0] b,
		logic blank, logic hs, logic vs);
		colour3_t b3;
		b3 = {1'b0, b} * 3'd2 + {2'b00, b[0]};
		if (blank) begin
			return {18'b0, hs, vs};
		end
		return {{3'b0, r} * 6'd9, {3'b0, g} * 6'd9, {3'b0, b3} * 6'd9, hs, vs}; // x9 repeats 3 bits
	endfunction

	task automatic abort_run(string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic expect_eq(string what, logic [31:0] got, logic [31:0] want);
		assert (got === want) else
			abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	task automatic apb_xfer(logic [7:0] addr, logic wr, status_t wdata,
		output status_t rdata, output logic err);
		int waited;
		@(posedge clock_24);
		paddr <= addr;
		pwrite <= wr;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge clock_24);
		penable <= 1'b1;
		waited = 0;
		@(negedge clock_24);
		while (!pready) begin
			waited++;
			if (waited > 16) begin
				abort_run("APB slave did not raise pready within 16 cycles");
			end
			@(negedge clock_24);
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clock_24);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic settle_ctrl(int edges);
		repeat (edges) @(posedge clock_24);
		exp_ctrl <= ref_controls(key_state, joystick_0, joystick_1, status_model);
		exp_reset <= ref_reset(status_model, reset_button);
	endtask

	task automatic set_status(status_t v);
		status_t rd;
		logic err;
		apb_xfer(`REG_STATUS, 1'b1, v, rd, err);
		expect_eq("status write pslverr", 32'(err), 32'd0);
		status_model = v;
		settle_ctrl(1);
	endtask

	task automatic read_expect(logic [7:0] addr, status_t want, string what);
		status_t rd;
		logic err;
		apb_xfer(addr, 1'b0, '0, rd, err);
		expect_eq({what, " pslverr"}, 32'(err), 32'd0);
		expect_eq(what, rd, want);
	endtask

	task automatic expect_slverr(logic [7:0] addr, logic wr, string what);
		status_t rd;
		logic err;
		apb_xfer(addr, wr, 32'hdead_beef, rd, err);
		expect_eq(what, 32'(err), 32'd1);
	endtask

	task automatic key_event(scancode_t code, logic pressed);
		@(posedge clock_24);
		key_code <= code;
		key_pressed <= pressed;
		key_strobe <= ~key_strobe;
		key_state = apply_key(key_state, code, pressed);
		settle_ctrl(2); // decoder edge, then mapper edge
		read_expect(`REG_BUTTONS, {23'b0, key_state}, "button read-back");
	endtask

	task automatic expect_game_reset(string why);
		@(negedge clock_24);
		expect_eq({"game_reset from ", why}, 32'(game_reset), 32'd1);
	endtask

	task automatic run_audio(sample_t s);
		int ones;
		@(posedge clock_24);
		audio_sample <= s;
		rst_n <= 1'b0;
		@(posedge clock_24);
		rst_n <= 1'b1;
		ones = 0;
		// first sample is the cleared accumulator, then 65536 adds
		repeat (65537) begin
			@(negedge clock_24);
			ones = ones + (audio_out ? 1 : 0);
		end
		expect_eq("audio ones count", 32'(ones), 32'(s));
	endtask

	always @(negedge clock_24) begin
		if (ctrl_check) begin
			assert ({game_start2, game_start1, game_coin, game_fire2, game_fire1, game_up,
				game_down, game_left, game_right, game_reset} === {exp_ctrl, exp_reset}) else
				abort_run($sformatf("ERR %0t: game controls %b, expected %b", $time,
					{game_start2, game_start1, game_coin, game_fire2, game_fire1, game_up,
					game_down, game_left, game_right, game_reset}, {exp_ctrl, exp_reset}));
		end
		if (video_check) begin
			assert ({vga_r, vga_g, vga_b, vga_hs, vga_vs} === exp_video) else
				abort_run($sformatf("ERR %0t: vga %h, expected %h", $time,
					{vga_r, vga_g, vga_b, vga_hs, vga_vs}, exp_video));
		end
	end

	initial begin
		status_t word;
		scancode_t code;
		logic pressed;
		logic [3:0] pick;
		rst_n <= 1'b0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		key_strobe <= 1'b0;
		key_pressed <= 1'b0;
		key_code <= '0;
		joystick_0 <= '0;
		joystick_1 <= '0;
		reset_button <= 1'b0;
		game_r <= '0;
		game_g <= '0;
		game_b <= '0;
		game_hblank <= 1'b0;
		game_vblank <= 1'b0;
		game_hs <= 1'b1;
		game_vs <= 1'b1;
		audio_sample <= '0;
		key_state = '0;
		status_model = '0;
		exp_ctrl <= '0;
		exp_reset <= 1'b0;
		exp_video <= {18'b0, 2'b11};
		ctrl_check <= 1'b0;
		video_check <= 1'b0;
		repeat (10) @(posedge clock_24);
		rst_n <= 1'b1;
		ctrl_check <= 1'b1;

		@(negedge clock_24);
		expect_eq("audio_out after reset", 32'(audio_out), 32'd0);
		expect_eq("syncs after reset", 32'({vga_hs, vga_vs}), 32'd3);
		read_expect(`REG_STATUS, '0, "status after reset");

		repeat (8) begin
			word = rand_bits(32) & ~32'h45; // keep rotate, reset and soft reset clear
			set_status(word);
			read_expect(`REG_STATUS, word, "status read-back");
		end
		expect_slverr(8'h08, 1'b0, "unmapped read pslverr");
		expect_slverr(8'h10, 1'b1, "unmapped write pslverr");
		expect_slverr(`REG_BUTTONS, 1'b1, "button write pslverr");
		read_expect(`REG_STATUS, status_model, "status after rejected writes");

		repeat (60) begin
			pick = 4'(rand_bits(4));
			code = (pick < 4'd9) ? key_table[pick] : scancode_t'(rand_bits(8));
			pressed = 1'(rand_bits(1));
			key_event(code, pressed);
		end

		for (int rot = 0; rot < 2; rot++) begin
			set_status(status_t'(rot) << `ST_ROTATE);
			repeat (20) begin
				@(posedge clock_24);
				joystick_0 <= joy_t'(rand_bits(8));
				joystick_1 <= joy_t'(rand_bits(8));
				settle_ctrl(1);
			end
		end
		set_status(32'h1 << `ST_RESET);
		expect_game_reset("status bit 0");
		set_status(32'h1 << `ST_SOFT_RESET);
		expect_game_reset("status bit 6");
		set_status('0);
		@(posedge clock_24);
		reset_button <= 1'b1;
		settle_ctrl(1);
		expect_game_reset("reset_button");
		@(posedge clock_24);
		reset_button <= 1'b0;
		settle_ctrl(1);

		video_check <= 1'b1;
		repeat (200) begin
			@(posedge clock_24);
			exp_video <= ref_video(game_r, game_g, game_b, game_hblank | game_vblank,
				game_hs, game_vs);
			game_r <= colour3_t'(rand_bits(3));
			game_g <= colour3_t'(rand_bits(3));
			game_b <= 2'(rand_bits(2));
			game_hblank <= (rand_bits(2) == 0);
			game_vblank <= (rand_bits(3) == 0);
			game_hs <= 1'(rand_bits(1));
			game_vs <= 1'(rand_bits(1));
		end
		@(posedge clock_24);
		video_check <= 1'b0;
		ctrl_check <= 1'b0; // reset pulses follow

		repeat (3) run_audio(sample_t'(rand_bits(16)));

		$display(">>> PASS");
		$finish;
	end

endmodule

/* src.f */
+incdir+.
arcade_pkg.sv
panel_if.sv
host_status_regs.sv
key_decoder.sv
control_mapper.sv
video_out.sv
audio_dac.sv
arcade_io_top.sv
arcade_io_assertions.sv
tb_arcade_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_arcade_io -f src.f -o sim_arcade_io
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_arcade_io > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q ">>> FAIL" "$log"; then
	echo "simulation reported failure"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
echo "simulation finished without failure"
exit 0
